//--- bht_table.sv
// branch history table
// 2-bit saturating direction counters, read at the fetch pc,
// trained by resolved branches, cleared by reset and flush
`timescale 1ns/1ps

module bht_table #(
    parameter int BHT_ENTRIES = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  bp_pkg::fetch_req_t fetch,
    input  bp_pkg::resolve_t   resolve,
    output bp_pkg::counter_t   state
);
    import bp_pkg::*;

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    counter_t         counters [BHT_ENTRIES];
    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] upd_idx;
    counter_t         cur_state;
    counter_t         next_state;

    // word aligned pc, index starts at bit 2
    assign fetch_idx = fetch.pc[IDX_W+1:2];
    assign upd_idx   = resolve.pc[IDX_W+1:2];

    assign cur_state = counters[upd_idx];

    // one step toward the resolved direction, saturating at both ends
    always_comb begin
        next_state = cur_state;
        case (cur_state)
            strong_not_taken: begin
                if (resolve.taken) begin
                    next_state = weak_not_taken;
                end
            end
            weak_not_taken: begin
                next_state = resolve.taken ? weak_taken : strong_not_taken;
            end
            weak_taken: begin
                next_state = resolve.taken ? strong_taken : weak_not_taken;
            end
            strong_taken: begin
                if (!resolve.taken) begin
                    next_state = weak_taken;
                end
            end
            default: next_state = strong_not_taken;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                counters[i] <= strong_not_taken;
            end
        end else if (resolve.valid) begin
            counters[upd_idx] <= next_state;
        end
    end

    // combinational lookup, a resolve is visible to the next fetch
    assign state = counters[fetch_idx];

endmodule

//--- bp_csr_axil.sv
// axi4-lite register block for the predictor
// ctrl register (enable, flush command) and lookup / branch / mispredict counters
`timescale 1ns/1ps

module bp_csr_axil (
    input  logic              clk,
    input  logic              reset,
    input  bp_pkg::axil_req_t axil_req,
    input  logic              lookup_event,
    input  logic              branch_event,
    input  logic              mispredict_event,
    output bp_pkg::axil_rsp_t axil_rsp,
    output logic              enable,
    output logic              flush
);
    import bp_pkg::*;

    logic        wr_accept;
    logic        rd_accept;
    logic        wr_addr_ok;
    logic        rd_addr_ok;
    logic [31:0] rd_data;
    logic [31:0] lookup_count;
    logic [31:0] branch_count;
    logic [31:0] mispredict_count;

    // a held response blocks the next transfer on that channel
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !axil_rsp.bvalid;
    assign rd_accept = axil_req.arvalid && !axil_rsp.rvalid;

    assign axil_rsp.awready = wr_accept;
    assign axil_rsp.wready  = wr_accept;
    assign axil_rsp.arready = rd_accept;

    assign wr_addr_ok = (axil_req.awaddr == reg_ctrl) || (axil_req.awaddr == reg_lookups) ||
                        (axil_req.awaddr == reg_branches) ||
                        (axil_req.awaddr == reg_mispredicts);

    always_comb begin
        rd_addr_ok = 1'b1;
        case (axil_req.araddr)
            reg_ctrl:        rd_data = {31'd0, enable};  // flush bit reads back 0
            reg_lookups:     rd_data = lookup_count;
            reg_branches:    rd_data = branch_count;
            reg_mispredicts: rd_data = mispredict_count;
            default: begin
                rd_data    = 32'd0;
                rd_addr_ok = 1'b0;
            end
        endcase
    end

    // ctrl register and flush pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b1;
            flush  <= 1'b0;
        end else begin
            flush <= wr_accept && (axil_req.awaddr == reg_ctrl) && axil_req.wdata[1];
            if (wr_accept && (axil_req.awaddr == reg_ctrl)) begin
                enable <= axil_req.wdata[0];
            end
        end
    end

    // event counters, any write clears
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_count     <= '0;
            branch_count     <= '0;
            mispredict_count <= '0;
        end else begin
            if (wr_accept && (axil_req.awaddr == reg_lookups)) begin
                lookup_count <= '0;
            end else if (lookup_event) begin
                lookup_count <= lookup_count + 32'd1;
            end
            if (wr_accept && (axil_req.awaddr == reg_branches)) begin
                branch_count <= '0;
            end else if (branch_event) begin
                branch_count <= branch_count + 32'd1;
            end
            if (wr_accept && (axil_req.awaddr == reg_mispredicts)) begin
                mispredict_count <= '0;
            end else if (mispredict_event) begin
                mispredict_count <= mispredict_count + 32'd1;
            end
        end
    end

    // write response channel
    always_ff @(posedge clk) begin
        if (reset) begin
            axil_rsp.bvalid <= 1'b0;
        end else if (wr_accept) begin
            axil_rsp.bvalid <= 1'b1;
            axil_rsp.bresp  <= wr_addr_ok ? resp_okay : resp_slverr;
        end else if (axil_req.bready) begin
            axil_rsp.bvalid <= 1'b0;
        end
    end

    // read data channel
    always_ff @(posedge clk) begin
        if (reset) begin
            axil_rsp.rvalid <= 1'b0;
        end else if (rd_accept) begin
            axil_rsp.rvalid <= 1'b1;
            axil_rsp.rdata  <= rd_data;
            axil_rsp.rresp  <= rd_addr_ok ? resp_okay : resp_slverr;
        end else if (axil_req.rready) begin
            axil_rsp.rvalid <= 1'b0;
        end
    end

endmodule

//--- bp_pkg.sv
// shared types for the branch prediction unit
// 2-bit counter states, fetch / prediction / resolve / redirect structs
// axi4-lite request and response structs, register offsets and response codes
package bp_pkg;

    // msb of the state is the predicted direction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic [31:0] pc;
        logic [31:0] target;  // pc + 4 when not taken
    } prediction_t;

    // one executed conditional branch, with what was predicted for it
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        pred_taken;
        logic [31:0] pred_target;
    } resolve_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [3:0] reg_ctrl        = 4'h0;
    localparam logic [3:0] reg_lookups     = 4'h4;
    localparam logic [3:0] reg_branches    = 4'h8;
    localparam logic [3:0] reg_mispredicts = 4'hC;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- branch_predictor_top.sv
// branch prediction unit top level
// direction table, target table, combining stage and axi4-lite register block
`timescale 1ns/1ps

module branch_predictor_top #(
    parameter int BHT_ENTRIES = 256,
    parameter int BTB_ENTRIES = 64
) (
    input  logic                clk,
    input  logic                reset,
    input  bp_pkg::fetch_req_t  fetch,
    input  bp_pkg::resolve_t    resolve,
    input  bp_pkg::axil_req_t   axil_req,
    output bp_pkg::prediction_t pred,
    output bp_pkg::redirect_t   redirect,
    output bp_pkg::axil_rsp_t   axil_rsp
);
    import bp_pkg::*;

    counter_t    bht_state;
    logic        btb_hit;
    logic [31:0] btb_target;
    logic        alloc_valid;
    logic [31:0] alloc_pc;
    logic [31:0] alloc_target;
    logic        enable;
    logic        flush;
    logic        lookup_event;
    logic        branch_event;
    logic        mispredict_event;

    bht_table #(
        .BHT_ENTRIES(BHT_ENTRIES)
    ) bht0 (
        .clk    (clk),
        .reset  (reset),
        .flush  (flush),
        .fetch  (fetch),
        .resolve(resolve),  // trained straight from the resolve port
        .state  (bht_state)
    );

    btb_table #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) btb0 (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch       (fetch),
        .alloc_valid (alloc_valid),
        .alloc_pc    (alloc_pc),
        .alloc_target(alloc_target),
        .hit         (btb_hit),
        .target      (btb_target)
    );

    pc_select sel0 (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .fetch           (fetch),
        .state           (bht_state),
        .btb_hit         (btb_hit),
        .btb_target      (btb_target),
        .resolve         (resolve),
        .pred            (pred),
        .redirect        (redirect),
        .alloc_valid     (alloc_valid),
        .alloc_pc        (alloc_pc),
        .alloc_target    (alloc_target),
        .lookup_event    (lookup_event),
        .branch_event    (branch_event),
        .mispredict_event(mispredict_event)
    );

    bp_csr_axil csr0 (
        .clk             (clk),
        .reset           (reset),
        .axil_req        (axil_req),
        .lookup_event    (lookup_event),
        .branch_event    (branch_event),
        .mispredict_event(mispredict_event),
        .axil_rsp        (axil_rsp),
        .enable          (enable),
        .flush           (flush)
    );

endmodule

//--- btb_table.sv
// branch target buffer
// direct-mapped table of tag, target and valid bit with hit lookup,
// allocate on taken branches, valid bits cleared by reset and flush
`timescale 1ns/1ps

module btb_table #(
    parameter int BTB_ENTRIES = 64
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  bp_pkg::fetch_req_t fetch,
    input  logic               alloc_valid,
    input  logic [31:0]        alloc_pc,
    input  logic [31:0]        alloc_target,
    output logic               hit,
    output logic [31:0]        target
);
    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;  // pc[31:IDX_W+2]

    logic [TAG_W-1:0]       tags    [BTB_ENTRIES];
    logic [31:0]            targets [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid;

    logic [IDX_W-1:0] fetch_idx;
    logic [TAG_W-1:0] fetch_tag;
    logic [IDX_W-1:0] alloc_idx;
    logic [TAG_W-1:0] alloc_tag;

    assign fetch_idx = fetch.pc[IDX_W+1:2];
    assign fetch_tag = fetch.pc[31:IDX_W+2];
    assign alloc_idx = alloc_pc[IDX_W+1:2];
    assign alloc_tag = alloc_pc[31:IDX_W+2];

    // valid bits are the only control state here
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= '0;
        end else if (alloc_valid) begin
            valid[alloc_idx] <= 1'b1;
        end
    end

    // tag and target storage, overwritten on allocate
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            tags[alloc_idx]    <= alloc_tag;
            targets[alloc_idx] <= alloc_target;
        end
    end

    assign hit    = fetch.valid && valid[fetch_idx] && (tags[fetch_idx] == fetch_tag);
    assign target = targets[fetch_idx];

endmodule

//--- pc_select.sv
// prediction combining stage
// registers the prediction from counter state and btb result,
// detects mispredicts on resolve, drives redirect, btb allocate and event pulses
`timescale 1ns/1ps

module pc_select (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  bp_pkg::fetch_req_t  fetch,
    input  bp_pkg::counter_t    state,
    input  logic                btb_hit,
    input  logic [31:0]         btb_target,
    input  bp_pkg::resolve_t    resolve,
    output bp_pkg::prediction_t pred,
    output bp_pkg::redirect_t   redirect,
    output logic                alloc_valid,
    output logic [31:0]         alloc_pc,
    output logic [31:0]         alloc_target,
    output logic                lookup_event,
    output logic                branch_event,
    output logic                mispredict_event
);
    import bp_pkg::*;

    prediction_t pred_next;
    logic        mispredict;
    logic [31:0] correct_pc;

    // taken needs a btb hit as well as a taken counter
    always_comb begin
        pred_next.valid  = fetch.valid;
        pred_next.taken  = enable && btb_hit && state[1];
        pred_next.pc     = fetch.pc;
        pred_next.target = pred_next.taken ? btb_target : fetch.pc + 32'd4;
    end

    assign mispredict = resolve.valid &&
                        ((resolve.taken != resolve.pred_taken) ||
                         (resolve.taken && (resolve.target != resolve.pred_target)));
    assign correct_pc = resolve.taken ? resolve.target : resolve.pc + 32'd4;

    // only taken branches get a btb entry
    assign alloc_valid  = resolve.valid && resolve.taken;
    assign alloc_pc     = resolve.pc;
    assign alloc_target = resolve.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            pred.valid       <= 1'b0;
            redirect.valid   <= 1'b0;
            lookup_event     <= 1'b0;
            branch_event     <= 1'b0;
            mispredict_event <= 1'b0;
        end else begin
            pred             <= pred_next;
            redirect.valid   <= mispredict;
            redirect.pc      <= correct_pc;
            lookup_event     <= fetch.valid;    // one pulse per lookup
            branch_event     <= resolve.valid;
            mispredict_event <= mispredict;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the branch predictor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_branch_predictor -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\* FAIL \*\*" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

//--- src.f
bp_pkg.sv
bht_table.sv
btb_table.sv
pc_select.sv
bp_csr_axil.sv
branch_predictor_top.sv
tb_branch_predictor.sv

//--- tb_branch_predictor.sv
// directed testbench for the branch prediction unit
// reference model of counters and btb, bus and port helpers, six tests
`timescale 1ns/1ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int BHT_ENTRIES = 256;
    localparam int BTB_ENTRIES = 64;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int TIMEOUT     = 50;
    localparam logic [3:0]  UNMAPPED = 4'h6;
    localparam logic [31:0] PC_A  = 32'h0000_1040;
    localparam logic [31:0] TGT_X = 32'h0000_2000;
    localparam logic [31:0] PC_B  = 32'h0000_3080;
    localparam logic [31:0] TGT_Y = 32'h0000_4000;
    localparam logic [31:0] PC_C  = 32'h0000_1440;  // same indexes as PC_A, other tag

    logic        clk;
    logic        reset;
    fetch_req_t  fetch;
    resolve_t    resolve;
    axil_req_t   axil_req;
    prediction_t pred;
    redirect_t   redirect;
    axil_rsp_t   axil_rsp;

    // reference model
    int          bht_m [BHT_ENTRIES];
    logic        btb_valid_m [BTB_ENTRIES];
    logic [31:0] btb_tag_m [BTB_ENTRIES];
    logic [31:0] btb_target_m [BTB_ENTRIES];
    logic        enable_m;
    int          lookups_m;
    int          branches_m;
    int          mispredicts_m;

    string       cur_test;
    int          errors;
    int          checks;
    int          tests;
    int          start_errors;
    integer      seed;

    branch_predictor_top #(
        .BHT_ENTRIES(BHT_ENTRIES),
        .BTB_ENTRIES(BTB_ENTRIES)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .fetch   (fetch),
        .resolve (resolve),
        .axil_req(axil_req),
        .pred    (pred),
        .redirect(redirect),
        .axil_rsp(axil_rsp)
    );

    always #20 clk = ~clk;

    function automatic int bht_index(logic [31:0] pc);
        return int'((pc >> 2) & 32'(BHT_ENTRIES - 1));
    endfunction

    function automatic int btb_index(logic [31:0] pc);
        return int'((pc >> 2) & 32'(BTB_ENTRIES - 1));
    endfunction

    function automatic logic [31:0] btb_tag(logic [31:0] pc);
        return pc >> (2 + BTB_IDX_W);
    endfunction

    function automatic logic model_taken(logic [31:0] pc);
        int ti;
        ti = btb_index(pc);
        return enable_m && btb_valid_m[ti] && (btb_tag_m[ti] == btb_tag(pc)) &&
               (bht_m[bht_index(pc)] >= 2);
    endfunction

    function automatic logic [31:0] model_target(logic [31:0] pc);
        return model_taken(pc) ? btb_target_m[btb_index(pc)] : pc + 32'd4;
    endfunction

    task automatic model_flush();
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            bht_m[i] = 0;  // strong not taken
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            btb_valid_m[i] = 1'b0;
        end
    endtask

    task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic start_test(string name);
        cur_test = name;
        start_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s finished, %0d errors", cur_test, errors - start_errors);
    endtask

    task automatic abort_on_timeout(string what);
        $display("timeout in test %s: %s", cur_test, what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic axil_write(logic [3:0] addr, logic [31:0] data, output logic [1:0] resp);
        int waited;
        waited = 0;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        @(posedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready) && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            abort_on_timeout("write address and data never accepted");
        end else begin
            @(negedge clk);
            axil_req.awvalid = 1'b0;
            axil_req.wvalid  = 1'b0;
            waited = 0;
            while (!axil_rsp.bvalid && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!axil_rsp.bvalid) begin
                abort_on_timeout("no write response");
            end else begin
                resp = axil_rsp.bresp;
                axil_req.bready = 1'b1;
                @(negedge clk);
                axil_req.bready = 1'b0;
            end
        end
    endtask

    task automatic axil_read(logic [3:0] addr, output logic [31:0] data, output logic [1:0] resp);
        int waited;
        waited = 0;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        @(posedge clk);
        while (!axil_rsp.arready && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!axil_rsp.arready) begin
            abort_on_timeout("read address never accepted");
        end else begin
            @(negedge clk);
            axil_req.arvalid = 1'b0;
            waited = 0;
            while (!axil_rsp.rvalid && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!axil_rsp.rvalid) begin
                abort_on_timeout("no read response");
            end else begin
                data = axil_rsp.rdata;
                resp = axil_rsp.rresp;
                axil_req.rready = 1'b1;
                @(negedge clk);
                axil_req.rready = 1'b0;
            end
        end
    endtask

    // ctrl write, mirrored into the model
    task automatic set_ctrl(logic [31:0] data);
        logic [1:0] resp;
        axil_write(reg_ctrl, data, resp);
        check("ctrl write resp", 32'(resp_okay), 32'(resp));
        enable_m = data[0];
        if (data[1]) begin
            model_flush();
        end
    endtask

    task automatic clear_counter(logic [3:0] addr);
        logic [1:0] resp;
        @(negedge clk);  // let pending event pulses land first
        axil_write(addr, 32'hFFFF_FFFF, resp);
        check("clear resp", 32'(resp_okay), 32'(resp));
        if (addr == reg_lookups) lookups_m = 0;
        if (addr == reg_branches) branches_m = 0;
        if (addr == reg_mispredicts) mispredicts_m = 0;
    endtask

    task automatic check_counters(string what);
        logic [31:0] data;
        logic [1:0]  resp;
        @(negedge clk);
        axil_read(reg_lookups, data, resp);
        check({what, " lookups"}, 32'(lookups_m), data);
        check({what, " lookups resp"}, 32'(resp_okay), 32'(resp));
        axil_read(reg_branches, data, resp);
        check({what, " branches"}, 32'(branches_m), data);
        check({what, " branches resp"}, 32'(resp_okay), 32'(resp));
        axil_read(reg_mispredicts, data, resp);
        check({what, " mispredicts"}, 32'(mispredicts_m), data);
        check({what, " mispredicts resp"}, 32'(resp_okay), 32'(resp));
    endtask

    task automatic do_fetch(logic [31:0] pc, output prediction_t p);
        fetch.valid = 1'b1;
        fetch.pc    = pc;
        @(negedge clk);
        p = pred;  // registered one cycle after the fetch
        fetch.valid = 1'b0;
        lookups_m++;
    endtask

    task automatic do_resolve(logic [31:0] pc, logic taken, logic [31:0] target,
                              logic pred_taken, logic [31:0] pred_target,
                              output redirect_t r);
        resolve.valid       = 1'b1;
        resolve.pc          = pc;
        resolve.taken       = taken;
        resolve.target      = target;
        resolve.pred_taken  = pred_taken;
        resolve.pred_target = pred_target;
        @(negedge clk);
        r = redirect;
        resolve.valid = 1'b0;
    endtask

    task automatic expect_pred(string what, logic [31:0] pc, logic exp_taken,
                               logic [31:0] exp_target);
        prediction_t p;
        do_fetch(pc, p);
        check({what, " valid"}, 32'd1, 32'(p.valid));
        check({what, " pc"}, pc, p.pc);
        check({what, " taken"}, 32'(exp_taken), 32'(p.taken));
        check({what, " target"}, exp_target, p.target);
    endtask

    task automatic expect_resolve(string what, logic [31:0] pc, logic taken, logic [31:0] target,
                                  logic pred_taken, logic [31:0] pred_target);
        redirect_t r;
        logic      mis;
        int        bi;
        int        ti;
        mis = (taken != pred_taken) || (taken && (target != pred_target));
        bi  = bht_index(pc);
        ti  = btb_index(pc);
        do_resolve(pc, taken, target, pred_taken, pred_target, r);
        check({what, " redirect valid"}, 32'(mis), 32'(r.valid));
        if (mis) begin
            check({what, " redirect pc"}, taken ? target : pc + 32'd4, r.pc);
        end
        if (taken && bht_m[bi] < 3) bht_m[bi]++;
        if (!taken && bht_m[bi] > 0) bht_m[bi]--;
        if (taken) begin
            btb_valid_m[ti]  = 1'b1;  // allocate on every taken branch
            btb_tag_m[ti]    = btb_tag(pc);
            btb_target_m[ti] = target;
        end
        branches_m++;
        if (mis) mispredicts_m++;
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        logic [1:0]  resp;
        start_test("reset");
        check("pred valid", 32'd0, 32'(pred.valid));
        check("redirect valid", 32'd0, 32'(redirect.valid));
        axil_read(reg_ctrl, data, resp);
        check("ctrl", 32'd1, data);
        check("ctrl resp", 32'(resp_okay), 32'(resp));
        check_counters("initial");
        axil_read(UNMAPPED, data, resp);
        check("unmapped read resp", 32'(resp_slverr), 32'(resp));
        check("unmapped read data", 32'd0, data);
        axil_write(UNMAPPED, 32'hFFFF_FFFF, resp);
        check("unmapped write resp", 32'(resp_slverr), 32'(resp));
        end_test();
    endtask

    task automatic test_training();
        start_test("training");
        expect_resolve("taken 1", PC_A, 1'b1, TGT_X, 1'b0, PC_A + 32'd4);
        expect_pred("after one", PC_A, 1'b0, PC_A + 32'd4);
        expect_resolve("taken 2", PC_A, 1'b1, TGT_X, 1'b0, PC_A + 32'd4);
        expect_pred("after two", PC_A, 1'b1, TGT_X);
        expect_resolve("not taken 1", PC_A, 1'b0, TGT_X, 1'b1, TGT_X);
        expect_resolve("not taken 2", PC_A, 1'b0, TGT_X, 1'b0, PC_A + 32'd4);
        expect_pred("untrained", PC_A, 1'b0, PC_A + 32'd4);
        end_test();
    endtask

    task automatic test_redirect();
        start_test("redirect");
        expect_resolve("wrong dir", PC_B, 1'b1, TGT_Y, 1'b0, PC_B + 32'd4);
        expect_resolve("correct", PC_B, 1'b1, TGT_Y, 1'b1, TGT_Y);
        expect_resolve("wrong target", PC_B, 1'b1, TGT_Y, 1'b1, TGT_Y + 32'd8);
        expect_resolve("wrong not taken", PC_B, 1'b0, TGT_Y, 1'b1, TGT_Y);
        expect_resolve("correct not taken", PC_B, 1'b0, TGT_Y, 1'b0, PC_B + 32'd4);
        check_counters("after redirects");
        end_test();
    endtask

    task automatic test_alias();
        start_test("alias");
        expect_resolve("train 1", PC_A, 1'b1, TGT_X, 1'b0, PC_A + 32'd4);
        expect_resolve("train 2", PC_A, 1'b1, TGT_X, 1'b0, PC_A + 32'd4);
        expect_pred("trained", PC_A, 1'b1, TGT_X);
        expect_pred("other tag", PC_C, 1'b0, PC_C + 32'd4);  // bht says taken, btb misses
        end_test();
    endtask

    task automatic test_control();
        logic [31:0] data;
        logic [1:0]  resp;
        start_test("control");
        set_ctrl(32'd0);
        expect_pred("disabled", PC_A, 1'b0, PC_A + 32'd4);
        set_ctrl(32'd1);
        expect_pred("enabled", PC_A, 1'b1, TGT_X);
        expect_resolve("train b 1", PC_B, 1'b1, TGT_Y, 1'b0, PC_B + 32'd4);
        expect_resolve("train b 2", PC_B, 1'b1, TGT_Y, 1'b0, PC_B + 32'd4);
        expect_pred("b trained", PC_B, 1'b1, TGT_Y);
        set_ctrl(32'd3);
        axil_read(reg_ctrl, data, resp);
        check("ctrl after flush", 32'd1, data);
        expect_pred("flushed a", PC_A, 1'b0, PC_A + 32'd4);
        expect_pred("flushed b", PC_B, 1'b0, PC_B + 32'd4);
        clear_counter(reg_lookups);
        clear_counter(reg_branches);
        clear_counter(reg_mispredicts);
        check_counters("cleared");
        end_test();
    endtask

    task automatic test_random_mix();
        // pairs share bht and btb indexes with different tags
        logic [31:0] pcs [8] = '{32'h1100, 32'h1500, 32'h1900, 32'h2100,
                                 32'h1140, 32'h1240, 32'h3140, 32'h1304};
        int          idx;
        logic [31:0] pc;
        logic [31:0] r;
        logic [31:0] target;
        logic        exp_taken;
        logic [31:0] exp_target;
        start_test("random");
        for (int n = 0; n < 200; n++) begin
            idx = $random(seed) & 7;
            pc  = pcs[idx];
            exp_taken  = model_taken(pc);
            exp_target = model_target(pc);
            expect_pred($sformatf("fetch %0d", n), pc, exp_taken, exp_target);
            r      = $random(seed);
            target = r[1] ? pc + 32'h80 : pc - 32'h40;
            expect_resolve($sformatf("resolve %0d", n), pc, r[0], target,
                           exp_taken, exp_target);
        end
        check_counters("final");
        end_test();
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        fetch    = '0;
        resolve  = '0;
        axil_req = '0;
        seed     = 95387;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        enable_m      = 1'b1;
        lookups_m     = 0;
        branches_m    = 0;
        mispredicts_m = 0;
        model_flush();
        repeat (5) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_training();
        test_redirect();
        test_alias();
        test_control();
        test_random_mix();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
